// ==== design/fp_types_pkg.sv ====
// Shared definitions for the divide and square-root subsystem.
// Format constants, iteration counts, tag and word types,
// and the packed issue payloads of both units.

package fp_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Number format.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int FP_WIDTH   = 32;   // Single-precision word.
    localparam int EXP_WIDTH  = 8;    // Biased exponent field.
    localparam int MANT_WIDTH = 23;   // Stored fraction, hidden bit not counted.
    localparam int EXP_BIAS   = 127;  // Exponent bias.
    localparam int TAG_WIDTH  = 3;    // Issuer tag.

    localparam int DIV_CYCLES  = 25;  // One compare plus 24 quotient bits.
    localparam int SQRT_CYCLES = 24;  // One root bit per iteration.

    localparam logic [FP_WIDTH-1:0] QNAN_WORD = 32'h7FC0_0000;  // Canonical quiet NaN.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [FP_WIDTH-1:0]  fp_word_t;  // Operand or result word.
    typedef logic [TAG_WIDTH-1:0] fp_tag_t;   // Returned with the result.

    typedef struct packed {
        fp_word_t a;    // Dividend.
        fp_word_t b;    // Divisor.
        fp_tag_t  tag;  // Issuer tag.
    } fp_div_inputs_t;  // 67 bits.

    typedef struct packed {
        fp_word_t a;    // Radicand.
        fp_tag_t  tag;  // Issuer tag.
    } fp_sqrt_inputs_t; // 35 bits.

endpackage

// ==== design/fp_input_buffer.sv ====
// One-entry operation buffer with a valid/ready input side.
// Holds a registered payload and a full bit; the pop of the
// same cycle frees the slot so back-to-back issue is sustained.

module fp_input_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_pop,
    output payload_t out_data
);

    logic     full;  // Slot occupied.
    logic     push;  // Handshake on the input side.
    payload_t data;  // Stored operation.

    assign push      = in_valid & in_ready;
    assign in_ready  = ~full | out_pop;  // Free now or freed this cycle.
    assign out_valid = full;
    assign out_data  = data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (push) begin
            full <= 1'b1;                // Refill wins over pop.
        end else if (out_pop) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data <= in_data;             // Visible next cycle.
        end
    end

endmodule

// ==== design/fp_div_core.sv ====
// Iterative restoring divider for normal single-precision operands.
// First iteration aligns the dividend, then one quotient bit per cycle.
// Result is truncated and held until the writeback ack.

module fp_div_core
    import fp_types_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           start,
    input  fp_div_inputs_t op,
    output logic           done,
    output fp_word_t       result,
    output fp_tag_t        tag,
    input  logic           ack
);

    logic                                busy;    // Iterating.
    logic [$clog2(DIV_CYCLES)-1:0]       count;   // Iteration index.
    logic                                sign_q;  // Result sign.
    logic [EXP_WIDTH-1:0]                exp_q;   // Result exponent.
    logic [MANT_WIDTH:0]                 mb;      // Divisor mantissa.
    logic [MANT_WIDTH+1:0]               rem;     // Partial remainder.
    logic [MANT_WIDTH+1:0]               diff;    // Trial subtraction.
    logic                                rem_ge;  // Remainder covers divisor.
    logic [MANT_WIDTH-1:0]               q;       // Quotient fraction.

    assign diff   = rem - {1'b0, mb};
    assign rem_ge = rem >= {1'b0, mb};
    assign result = {sign_q, exp_q, q};  // Leading one shifted out of q.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == ($clog2(DIV_CYCLES))'(DIV_CYCLES - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;         // DIV_CYCLES+1 after start.
                end
            end
            if (ack) begin
                done <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (start) begin
            sign_q <= op.a[FP_WIDTH-1] ^ op.b[FP_WIDTH-1];
            exp_q  <= op.a[FP_WIDTH-2 -: EXP_WIDTH] - op.b[FP_WIDTH-2 -: EXP_WIDTH]
                      + EXP_WIDTH'(EXP_BIAS);
            rem    <= {2'b01, op.a[MANT_WIDTH-1:0]};  // Hidden bit restored.
            mb     <= {1'b1, op.b[MANT_WIDTH-1:0]};
            tag    <= op.tag;
        end else if (busy) begin
            if (count == '0) begin
                if (!rem_ge) begin
                    rem   <= {rem[MANT_WIDTH:0], 1'b0};  // Align so quotient is in [1,2).
                    exp_q <= exp_q - 1'b1;
                end
            end else if (rem_ge) begin
                rem <= {diff[MANT_WIDTH:0], 1'b0};       // Keep the difference.
                q   <= {q[MANT_WIDTH-2:0], 1'b1};
            end else begin
                rem <= {rem[MANT_WIDTH:0], 1'b0};        // Restore by skipping.
                q   <= {q[MANT_WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== design/fp_sqrt_core.sv ====
// Iterative non-restoring square root for normal operands.
// Halves the unbiased exponent and develops one root bit per cycle.
// A negative operand returns the quiet NaN with invalid set.

module fp_sqrt_core
    import fp_types_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  fp_sqrt_inputs_t op,
    output logic            done,
    output fp_word_t        result,
    output fp_tag_t         tag,
    output logic            invalid,
    input  logic            ack
);

    logic                            busy;       // Iterating.
    logic [$clog2(SQRT_CYCLES)-1:0]  count;      // Iteration index.
    logic [EXP_WIDTH:0]              exp_sum;    // Biased exponent plus bias.
    logic [EXP_WIDTH-1:0]            exp_q;      // Result exponent.
    logic [2*MANT_WIDTH+1:0]         rad;        // Radicand, consumed two bits a cycle.
    logic [MANT_WIDTH+2:0]           rem;        // Signed partial remainder.
    logic [MANT_WIDTH+2:0]           rem_shift;
    logic [MANT_WIDTH+2:0]           rem_next;
    logic [MANT_WIDTH:0]             root;       // Root developed so far.

    // (ea + 127) / 2 covers both exponent parities.
    assign exp_sum = {1'b0, op.a[FP_WIDTH-2 -: EXP_WIDTH]} + (EXP_WIDTH+1)'(EXP_BIAS);
    assign result  = invalid ? QNAN_WORD : {1'b0, exp_q, root[MANT_WIDTH-1:0]};

    always_comb begin
        rem_shift = {rem[MANT_WIDTH:0], rad[2*MANT_WIDTH+1 -: 2]};  // Bring down two bits.
        if (rem[MANT_WIDTH+2]) begin
            rem_next = rem_shift + {root, 2'b11};  // Add back while negative.
        end else begin
            rem_next = rem_shift - {root, 2'b01};  // Subtract while positive.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            if (start) begin
                if (op.a[FP_WIDTH-1]) begin
                    done <= 1'b1;            // Negative operand skips the iterations.
                end else begin
                    busy  <= 1'b1;
                    count <= '0;
                end
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == ($clog2(SQRT_CYCLES))'(SQRT_CYCLES - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;            // SQRT_CYCLES+1 after start.
                end
            end
            if (ack) begin
                done <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (start) begin
            invalid <= op.a[FP_WIDTH-1];
            tag     <= op.tag;
            exp_q   <= exp_sum[EXP_WIDTH:1];
            // Odd exponent takes ma*2^24, even takes ma*2^23.
            rad     <= {1'b1, op.a[MANT_WIDTH-1:0], {(MANT_WIDTH+1){1'b0}}} >> op.a[MANT_WIDTH];
            rem     <= '0;
            root    <= '0;
        end else if (busy) begin
            rem  <= rem_next;
            root <= {root[MANT_WIDTH-1:0], ~rem_next[MANT_WIDTH+2]};  // Sign picks the bit.
            rad  <= {rad[2*MANT_WIDTH-1:0], 2'b00};
        end
    end

endmodule

// ==== design/fp_div_unit.sv ====
// Divide execution unit.
// One-entry issue buffer, running flag and the divide core.

module fp_div_unit
    import fp_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid,
    output logic     ready,
    input  fp_word_t a,
    input  fp_word_t b,
    input  fp_tag_t  tag,
    output logic     done,
    output fp_word_t result,
    output fp_tag_t  done_tag,
    input  logic     ack
);

    logic           running;    // Core busy or awaiting writeback.
    logic           start;      // Launch the core.
    logic           buf_valid;  // Operation waiting.
    fp_div_inputs_t issue_data;
    fp_div_inputs_t buf_data;

    assign issue_data = '{a: a, b: b, tag: tag};
    assign start      = buf_valid & ~running;  // Pop and launch together.

    fp_input_buffer #(
        .payload_t (fp_div_inputs_t)
    ) i_input_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (valid),
        .in_ready  (ready),
        .in_data   (issue_data),
        .out_valid (buf_valid),
        .out_pop   (start),
        .out_data  (buf_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else if (start) begin
            running <= 1'b1;  // Set beats clear.
        end else if (ack) begin
            running <= 1'b0;
        end
    end

    fp_div_core i_fp_div_core (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .op     (buf_data),
        .done   (done),
        .result (result),
        .tag    (done_tag),
        .ack    (ack)
    );

endmodule

// ==== design/fp_sqrt_unit.sv ====
// Square-root execution unit.
// One-entry issue buffer, running flag and the square-root core.

module fp_sqrt_unit
    import fp_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid,
    output logic     ready,
    input  fp_word_t a,
    input  fp_tag_t  tag,
    output logic     done,
    output fp_word_t result,
    output fp_tag_t  done_tag,
    output logic     invalid,
    input  logic     ack
);

    logic            running;    // Core busy or awaiting writeback.
    logic            start;      // Launch the core.
    logic            buf_valid;  // Operation waiting.
    fp_sqrt_inputs_t issue_data;
    fp_sqrt_inputs_t buf_data;

    assign issue_data = '{a: a, tag: tag};
    assign start      = buf_valid & ~running;

    fp_input_buffer #(
        .payload_t (fp_sqrt_inputs_t)
    ) i_input_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (valid),
        .in_ready  (ready),
        .in_data   (issue_data),
        .out_valid (buf_valid),
        .out_pop   (start),
        .out_data  (buf_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else if (start) begin
            running <= 1'b1;  // Set beats clear.
        end else if (ack) begin
            running <= 1'b0;  // Freed once the result leaves.
        end
    end

    fp_sqrt_core i_fp_sqrt_core (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .op      (buf_data),
        .done    (done),
        .result  (result),
        .tag     (done_tag),
        .invalid (invalid),
        .ack     (ack)
    );

endmodule

// ==== design/fp_wb_arbiter.sv ====
// Round-robin arbiter for the shared writeback bus.
// Combinational from done to wb_valid; the grant is locked while
// a presented result is stalled, and priority rotates per transfer.

module fp_wb_arbiter
    import fp_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     div_done,
    input  fp_word_t div_result,
    input  fp_tag_t  div_tag,
    output logic     div_ack,
    input  logic     sqrt_done,
    input  fp_word_t sqrt_result,
    input  fp_tag_t  sqrt_tag,
    input  logic     sqrt_invalid,
    output logic     sqrt_ack,
    output logic     wb_valid,
    input  logic     wb_ready,
    output fp_word_t wb_result,
    output fp_tag_t  wb_tag,
    output logic     wb_invalid
);

    logic prio;      // High gives square root the tie.
    logic hold;      // Grant locked by a stall.
    logic hold_sel;  // Locked grant.
    logic sel;       // High grants square root.
    logic xfer;      // Result accepted.

    always_comb begin
        if (hold) begin
            sel = hold_sel;              // Keep the stalled result.
        end else if (div_done & sqrt_done) begin
            sel = prio;
        end else begin
            sel = sqrt_done;
        end
    end

    assign wb_valid   = div_done | sqrt_done;
    assign xfer       = wb_valid & wb_ready;
    assign wb_result  = sel ? sqrt_result : div_result;
    assign wb_tag     = sel ? sqrt_tag : div_tag;
    assign wb_invalid = sel & sqrt_invalid;  // Only square root flags.
    assign div_ack    = xfer & ~sel;
    assign sqrt_ack   = xfer & sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio <= 1'b0;
            hold <= 1'b0;
        end else begin
            hold <= wb_valid & ~wb_ready;
            if (xfer) begin
                prio <= ~sel;            // Loser goes first next.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid & ~wb_ready) begin
            hold_sel <= sel;
        end
    end

endmodule

// ==== design/fp_div_sqrt_top.sv ====
// Top level of the divide and square-root subsystem.
// Two execution units sharing one writeback bus through
// the round-robin arbiter.

module fp_div_sqrt_top
    import fp_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     div_valid,
    output logic     div_ready,
    input  fp_word_t div_a,
    input  fp_word_t div_b,
    input  fp_tag_t  div_tag,
    input  logic     sqrt_valid,
    output logic     sqrt_ready,
    input  fp_word_t sqrt_a,
    input  fp_tag_t  sqrt_tag,
    output logic     wb_valid,
    input  logic     wb_ready,
    output fp_word_t wb_result,
    output fp_tag_t  wb_tag,
    output logic     wb_invalid
);

    logic     div_done;        // Divide result waiting.
    fp_word_t div_result;
    fp_tag_t  div_done_tag;
    logic     div_ack;
    logic     sqrt_done;       // Square-root result waiting.
    fp_word_t sqrt_result;
    fp_tag_t  sqrt_done_tag;
    logic     sqrt_invalid;
    logic     sqrt_ack;

    fp_div_unit i_fp_div_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .valid    (div_valid),
        .ready    (div_ready),
        .a        (div_a),
        .b        (div_b),
        .tag      (div_tag),
        .done     (div_done),
        .result   (div_result),
        .done_tag (div_done_tag),
        .ack      (div_ack)
    );

    fp_sqrt_unit i_fp_sqrt_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .valid    (sqrt_valid),
        .ready    (sqrt_ready),
        .a        (sqrt_a),
        .tag      (sqrt_tag),
        .done     (sqrt_done),
        .result   (sqrt_result),
        .done_tag (sqrt_done_tag),
        .invalid  (sqrt_invalid),
        .ack      (sqrt_ack)
    );

    fp_wb_arbiter i_fp_wb_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .div_done     (div_done),
        .div_result   (div_result),
        .div_tag      (div_done_tag),
        .div_ack      (div_ack),
        .sqrt_done    (sqrt_done),
        .sqrt_result  (sqrt_result),
        .sqrt_tag     (sqrt_done_tag),
        .sqrt_invalid (sqrt_invalid),
        .sqrt_ack     (sqrt_ack),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_result    (wb_result),
        .wb_tag       (wb_tag),
        .wb_invalid   (wb_invalid)
    );

endmodule

// ==== testbench/fp_ref_model.svh ====
// Reference model for the divide and square-root testbench.
// Truncating divide and square root on normal operands,
// and the Fibonacci LFSR random source.

`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Truncated quotient of two normal words.
function automatic fp_word_t ref_fp_div(input fp_word_t a, input fp_word_t b);
    logic [63:0] ma;
    logic [63:0] mb;
    logic [63:0] quo;
    int          exp_r;
    ma = {40'd0, 1'b1, a[MANT_WIDTH-1:0]};        // Hidden bit restored.
    mb = {40'd0, 1'b1, b[MANT_WIDTH-1:0]};
    if (ma >= mb) begin
        exp_r = int'(a[30:23]) - int'(b[30:23]) + EXP_BIAS;
        quo   = (ma << 23) / mb;                   // Quotient in [1,2).
    end else begin
        exp_r = int'(a[30:23]) - int'(b[30:23]) + EXP_BIAS - 1;
        quo   = (ma << 24) / mb;                   // One extra bit of scale.
    end
    return {a[31] ^ b[31], exp_r[7:0], quo[MANT_WIDTH-1:0]};
endfunction

// Square root as {invalid, word}. Negative operands give the quiet NaN.
function automatic logic [32:0] ref_fp_sqrt(input fp_word_t a);
    logic [63:0] rad;
    logic [63:0] root;
    logic [63:0] trial;
    int          e;
    int          exp_r;
    int          i;
    if (a[31]) begin
        return {1'b1, QNAN_WORD};
    end
    e   = int'(a[30:23]) - EXP_BIAS;               // Unbiased exponent.
    rad = {40'd0, 1'b1, a[MANT_WIDTH-1:0]};
    if (e % 2 == 0) begin
        rad   = rad << 23;
        exp_r = e / 2 + EXP_BIAS;
    end else begin
        rad   = rad << 24;
        exp_r = (e - 1) / 2 + EXP_BIAS;            // Exact for odd e.
    end
    root = '0;
    for (i = 23; i >= 0; i--) begin                // Largest root whose square fits.
        trial = root | (64'd1 << i);
        if (trial * trial <= rad) begin
            root = trial;
        end
    end
    return {1'b0, 1'b0, exp_r[7:0], root[MANT_WIDTH-1:0]};
endfunction

// Takes n bits from the LFSR with one step per bit.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};       // Taps 32, 22, 2, 1.
        val        = {val[30:0], fb};
    end
    return val;
endfunction

`endif

// ==== testbench/fp_div_sqrt_tb.sv ====
// Testbench for the divide and square-root subsystem.
// Directed and random issue on both ports, a tagged scoreboard
// checked at writeback, and a stall stability check on the bus.

module fp_div_sqrt_tb
    import fp_types_pkg::*;
();

    localparam int N_DIRECTED     = 4;
    localparam int N_RAND         = 200;
    localparam int N_NEG          = 16;
    localparam int N_MIX          = 100;    // Per unit.
    localparam int TOTAL_OPS      = N_DIRECTED + 2 * N_RAND + N_NEG + 2 * N_MIX;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * (SQRT_CYCLES + DIV_CYCLES + 8) * 4;

    logic        clk;
    logic        arst_n;
    logic        div_valid;
    logic        div_ready;
    fp_word_t    div_a;
    fp_word_t    div_b;
    fp_tag_t     div_tag;
    logic        sqrt_valid;
    logic        sqrt_ready;
    fp_word_t    sqrt_a;
    fp_tag_t     sqrt_tag;
    logic        wb_valid;
    logic        wb_ready;
    fp_word_t    wb_result;
    fp_tag_t     wb_tag;
    logic        wb_invalid;

    logic [31:0] lfsr_state;                // Random source state.
    fp_word_t    exp_word [8];              // Expected result per tag.
    logic        exp_flag [8];              // Expected invalid per tag.
    logic        tag_busy [8];              // Tag outstanding.
    int          issued;
    int          received;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    logic        bp_mode;                   // Random wb_ready when set.

    `include "fp_ref_model.svh"

    fp_div_sqrt_top i_fp_div_sqrt_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .div_valid  (div_valid),
        .div_ready  (div_ready),
        .div_a      (div_a),
        .div_b      (div_b),
        .div_tag    (div_tag),
        .sqrt_valid (sqrt_valid),
        .sqrt_ready (sqrt_ready),
        .sqrt_a     (sqrt_a),
        .sqrt_tag   (sqrt_tag),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_result  (wb_result),
        .wb_tag     (wb_tag),
        .wb_invalid (wb_invalid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // Period 8.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers. Callers sit 1 time unit after a rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic fp_word_t rand_operand(input logic sign);
        logic [7:0]  exp_f;
        logic [22:0] frac;
        exp_f = 8'(64 + rand_bits(7) % 126);       // 64..189 keeps results normal.
        frac  = 23'(rand_bits(23));
        return {sign, exp_f, frac};
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Takes a free tag and records the expected result under it.
    task automatic claim_tag(input logic [32:0] expected, output fp_tag_t tag);
        int found;
        int t;
        found = -1;
        while (found < 0) begin
            for (t = 0; t < 8; t++) begin
                if (!tag_busy[t] && found < 0) begin
                    found = t;
                end
            end
            if (found < 0) begin
                idle_cycles(1);                     // Wait for a free tag.
            end
        end
        tag             = fp_tag_t'(found);
        tag_busy[found] = 1'b1;
        exp_word[found] = expected[31:0];
        exp_flag[found] = expected[32];
        issued++;
    endtask

    task automatic issue_div(input fp_word_t a, input fp_word_t b);
        fp_tag_t tag;
        claim_tag({1'b0, ref_fp_div(a, b)}, tag);
        div_valid = 1'b1;
        div_a     = a;
        div_b     = b;
        div_tag   = tag;
        @(negedge clk);
        while (!div_ready) begin
            @(negedge clk);                         // Held stable while stalled.
        end
        idle_cycles(1);
        div_valid = 1'b0;
    endtask

    task automatic issue_sqrt(input fp_word_t a);
        fp_tag_t tag;
        claim_tag(ref_fp_sqrt(a), tag);
        sqrt_valid = 1'b1;
        sqrt_a     = a;
        sqrt_tag   = tag;
        @(negedge clk);
        while (!sqrt_ready) begin
            @(negedge clk);
        end
        idle_cycles(1);
        sqrt_valid = 1'b0;
    endtask

    task automatic random_divs(input int n);
        fp_word_t a;
        fp_word_t b;
        repeat (n) begin
            a = rand_operand(rand_bits(1) != 0);
            b = rand_operand(rand_bits(1) != 0);
            issue_div(a, b);
            idle_cycles(rand_bits(2));              // Random gap.
        end
    endtask

    task automatic random_sqrts(input int n, input logic neg);
        repeat (n) begin
            issue_sqrt(rand_operand(neg));
            idle_cycles(rand_bits(2));
        end
    endtask

    // Waits until every issued operation has come back.
    task automatic drain();
        wait (received == issued);
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, errors - mark);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback comparison on the falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_result();
        int t;
        t = int'(wb_tag);
        assert (tag_busy[t]) else begin
            $display("Result at %0t carries tag %0d with no operation outstanding", $time, t);
            errors++;
        end
        if (tag_busy[t]) begin
            assert (wb_result === exp_word[t]) else begin
                $display("Mismatch at %0t: wb_result expected %h, got %h",
                         $time, exp_word[t], wb_result);
                errors++;
            end
            assert (wb_invalid === exp_flag[t]) else begin
                $display("Mismatch at %0t: wb_invalid expected %b, got %b",
                         $time, exp_flag[t], wb_invalid);
                errors++;
            end
            tag_busy[t] = 1'b0;                     // Leaves on the next edge.
        end
        received++;
    endtask

    initial begin : writeback
        logic     stalled;
        fp_word_t held_result;
        fp_tag_t  held_tag;
        stalled = 1'b0;
        wait (arst_n);
        forever begin
            @(posedge clk);
            #1;
            wb_ready = bp_mode ? rand_bits(1) != 0 : 1'b1;
            @(negedge clk);
            if (stalled) begin
                assert (wb_valid) else begin
                    $display("Stalled result withdrawn at %0t", $time);
                    errors++;
                end
                assert (wb_result === held_result) else begin
                    $display("Mismatch at %0t: wb_result expected %h, got %h",
                             $time, held_result, wb_result);
                    errors++;
                end
                assert (wb_tag === held_tag) else begin
                    $display("Mismatch at %0t: wb_tag expected %0d, got %0d",
                             $time, held_tag, wb_tag);
                    errors++;
                end
            end
            stalled     = wb_valid & ~wb_ready;
            held_result = wb_result;
            held_tag    = wb_tag;
            if (wb_valid && wb_ready) begin
                check_result();
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles: results never arrived, %0d of %0d returned",
                 cycle_count, received, issued);
        $display("Simulation failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main
        int mark;
        int t;
        arst_n       = 1'b0;
        div_valid    = 1'b0;
        div_a        = '0;
        div_b        = '0;
        div_tag      = '0;
        sqrt_valid   = 1'b0;
        sqrt_a       = '0;
        sqrt_tag     = '0;
        wb_ready     = 1'b0;
        bp_mode      = 1'b0;
        lfsr_state   = 32'd79309;
        issued       = 0;
        received     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (t = 0; t < 8; t++) begin
            tag_busy[t] = 1'b0;
        end
        repeat (8) @(posedge clk);                  // Reset for 8 cycles.
        #1;
        arst_n = 1'b1;

        mark = errors;
        @(negedge clk);
        assert (wb_valid === 1'b0) else begin
            $display("Mismatch at %0t: wb_valid expected 0, got %b", $time, wb_valid);
            errors++;
        end
        assert (div_ready === 1'b1 && sqrt_ready === 1'b1) else begin
            $display("Mismatch at %0t: div_ready/sqrt_ready expected 1/1, got %b/%b",
                     $time, div_ready, sqrt_ready);
            errors++;
        end
        report_test("reset state", mark);
        idle_cycles(1);

        mark = errors;
        issue_div(32'h40C0_0000, 32'h4040_0000);    // 6.0 / 3.0.
        issue_div(32'h3F80_0000, 32'h4040_0000);    // 1.0 / 3.0, smaller mantissa.
        issue_div(32'hC0F0_0000, 32'h4020_0000);    // -7.5 / 2.5.
        issue_div(32'h3F80_0000, 32'h3FC0_0000);    // 1.0 / 1.5.
        drain();
        report_test("directed division", mark);

        mark = errors;
        random_divs(N_RAND);
        drain();
        report_test("random division", mark);

        mark = errors;
        random_sqrts(N_RAND, 1'b0);
        drain();
        report_test("random square root", mark);

        mark = errors;
        random_sqrts(N_NEG, 1'b1);
        drain();
        report_test("negative square root", mark);

        mark    = errors;
        bp_mode = 1'b1;
        fork
            random_divs(N_MIX);
            random_sqrts(N_MIX, 1'b0);
        join
        drain();
        report_test("shared bus back-pressure", mark);

        $display("Tests run: %0d, failed: %0d, errors: %0d, results checked: %0d of %0d",
                 tests_run, tests_failed, errors, received, issued);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== fp_div_sqrt.f ====
+incdir+testbench
design/fp_types_pkg.sv
design/fp_input_buffer.sv
design/fp_div_core.sv
design/fp_sqrt_core.sv
design/fp_div_unit.sv
design/fp_sqrt_unit.sv
design/fp_wb_arbiter.sv
design/fp_div_sqrt_top.sv
testbench/fp_div_sqrt_tb.sv

// ==== Bender.yml ====
package:
  name: fp_div_sqrt

sources:
  # Design sources in compile order.
  - design/fp_types_pkg.sv
  - design/fp_input_buffer.sv
  - design/fp_div_core.sv
  - design/fp_sqrt_core.sv
  - design/fp_div_unit.sv
  - design/fp_sqrt_unit.sv
  - design/fp_wb_arbiter.sv
  - design/fp_div_sqrt_top.sv

  # Testbench, top module fp_div_sqrt_tb.
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/fp_div_sqrt_tb.sv
